/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rvCore_tb
FILELIST  = rvCore.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/alu.sv */
`include "rv_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module alu import rv_pkg::*; (
    input  logic [`XLEN-1:0] srcA,
    input  logic [`XLEN-1:0] srcB,
    input  aluOpT            aluOp,
    output logic [`XLEN-1:0] result,
    output logic             zero,
    output logic             lessThan
);

    logic [4:0] shamt;
    logic       lessThanU;

    assign shamt     = srcB[4:0];
    assign lessThan  = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;

    always_comb begin
        case (aluOp)
            aluSub:  result = srcA - srcB;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluXor:  result = srcA ^ srcB;
            aluSlt:  result = {{(`XLEN-1){1'b0}}, lessThan};
            aluSltu: result = {{(`XLEN-1){1'b0}}, lessThanU};
            aluSll:  result = srcA << shamt;
            aluSrl:  result = srcA >> shamt;
            aluSra:  result = $unsigned($signed(srcA) >>> shamt);
            default: result = srcA + srcB;
        endcase
    end

    // Equality flag for beq and bne
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* design/dataMemory.sv */
`include "rv_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module dataMemory import rv_pkg::*; (
    input  logic             clk,
    input  logic             run,
    input  logic             memWrite,
    input  resultSelT        resultSel,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] writeData,
    input  logic [`XLEN-1:0] aluResult,
    input  logic [`XLEN-1:0] pcPlus4,
    output logic [`XLEN-1:0] result
);

    logic [`XLEN-1:0]    dmem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] wordIdx;
    logic [`XLEN-1:0]    readData;

    // Word access only with the byte offset ignored
    assign wordIdx = addr[`DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (run && memWrite) begin
            dmem[wordIdx] <= writeData;
        end
    end

    assign readData = dmem[wordIdx];

    // Register write-back source
    always_comb begin
        case (resultSel)
            resMem:  result = readData;
            resPc4:  result = pcPlus4;
            default: result = aluResult;
        endcase
    end

endmodule

`default_nettype wire

/* design/decoder.sv */
`include "rv_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module decoder import rv_pkg::*; (
    input  logic [`XLEN-1:0] instr,
    output ctrlT             ctrl,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [4:0]       rd,
    output logic [`XLEN-1:0] imm
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    // Maps funct3 to an ALU op with alt selecting sub or sra
    function automatic aluOpT aluFn(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    assign opcode   = opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        ctrl.regWrite   = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.aluSrcImm  = 1'b0;
        ctrl.aluOp      = aluAdd;
        ctrl.resultSel  = resAlu;
        ctrl.pcSel      = pcSelPlus4;
        // beq 000, bne 001, blt 100, bge 101
        ctrl.branchCond = {funct3[2], funct3[0]};
        ctrl.immKind    = immI;
        rs1             = instr[19:15];

        case (opcode)
            opReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFn(funct3, funct7b5);
            end
            opImm: begin
                // Bit 30 is part of the immediate except for shifts right
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluFn(funct3, funct7b5 && (funct3 == 3'b101));
            end
            opLui: begin
                // Reads x0 so the add passes the immediate through
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immKind   = immU;
                rs1            = 5'd0;
            end
            opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.resultSel = resMem;
            end
            opStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immKind   = immS;
            end
            opBranch: begin
                ctrl.aluOp   = aluSub;
                ctrl.pcSel   = pcSelBranch;
                ctrl.immKind = immB;
            end
            opJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSel = resPc4;
                ctrl.pcSel     = pcSelJal;
                ctrl.immKind   = immJ;
            end
            opJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.resultSel = resPc4;
                ctrl.pcSel     = pcSelJalr;
            end
            default: begin
                // Unknown opcodes keep the defaults with no writes
            end
        endcase
    end

    // Sign-extended immediate per format
    always_comb begin
        case (ctrl.immKind)
            immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
            immU: imm = {instr[31:12], 12'b0};
            immJ: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

/* design/fetchUnit.sv */
`include "rv_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module fetchUnit import rv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    input  logic             loadReq,
    input  loadWordT         loadWord,
    input  ctrlT             ctrl,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] aluResult,
    input  logic             zero,
    input  logic             lessThan,
    output logic             loadAck,
    output logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] pcPlus4
);

    typedef enum logic {
        loadIdle,
        loadAcked
    } loadStateT;

    loadStateT        loadState;
    logic             loadAccept;
    logic             taken;
    logic [`XLEN-1:0] pcTarget;
    logic [`XLEN-1:0] pcNext;

    logic [`XLEN-1:0] imem [`IMEM_WORDS];

    // Four-phase load port that accepts requests only in load mode
    assign loadAccept = (loadState == loadIdle) && loadReq && !run;
    assign loadAck    = (loadState == loadAcked);

    always_ff @(posedge clk) begin
        if (rst) begin
            loadState <= loadIdle;
        end else begin
            case (loadState)
                loadIdle:  if (loadAccept) loadState <= loadAcked;
                loadAcked: if (!loadReq) loadState <= loadIdle;
                default:   loadState <= loadIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (loadAccept) begin
            imem[loadWord.addr] <= loadWord.data;
        end
    end

    assign instr    = imem[pc[`IMEM_AW+1:2]];
    assign pcPlus4  = pc + 4;
    assign pcTarget = pc + imm;

    // Branch outcome from the ALU flags
    always_comb begin
        case (ctrl.branchCond)
            2'b00:   taken = zero;
            2'b01:   taken = !zero;
            2'b10:   taken = lessThan;
            default: taken = !lessThan;
        endcase
    end

    always_comb begin
        case (ctrl.pcSel)
            pcSelBranch: pcNext = taken ? pcTarget : pcPlus4;
            pcSelJal:    pcNext = pcTarget;
            pcSelJalr:   pcNext = {aluResult[`XLEN-1:1], 1'b0};
            default:     pcNext = pcPlus4;
        endcase
    end

    // PC parked at zero in load mode
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

/* design/regFile.sv */
`include "rv_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  logic             clk,
    input  logic             run,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic             regWrite,
    input  logic [`XLEN-1:0] writeData,
    output logic [`XLEN-1:0] readData1,
    output logic [`XLEN-1:0] readData2,
    output logic [`XLEN-1:0] a0,
    output logic [`XLEN-1:0] a1,
    output logic [`XLEN-1:0] a7
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (run && regWrite && (rd != 5'd0)) begin
            regs[rd] <= writeData;
        end
    end

    // x0 reads as zero whatever the array holds
    assign readData1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign readData2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    assign a0 = regs[10];
    assign a1 = regs[11];
    assign a7 = regs[17];

endmodule

`default_nettype wire

/* design/rvCore.sv */
`include "rv_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module rvCore import rv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    input  logic             loadReq,
    input  loadWordT         loadWord,
    output logic             loadAck,
    output logic [`XLEN-1:0] a0,
    output logic [`XLEN-1:0] a1,
    output logic [`XLEN-1:0] a7
);

    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pcPlus4;

    ctrlT             ctrl;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic [`XLEN-1:0] imm;

    logic [`XLEN-1:0] readData1;
    logic [`XLEN-1:0] readData2;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;
    logic             zero;
    logic             lessThan;
    logic [`XLEN-1:0] writeBack;

    // Second ALU operand
    assign srcB = ctrl.aluSrcImm ? imm : readData2;

    fetchUnit fetch_i (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .loadReq   (loadReq),
        .loadWord  (loadWord),
        .ctrl      (ctrl),
        .imm       (imm),
        .aluResult (aluResult),
        .zero      (zero),
        .lessThan  (lessThan),
        .loadAck   (loadAck),
        .instr     (instr),
        .pc        (),
        .pcPlus4   (pcPlus4)
    );

    decoder decoder_i (
        .instr (instr),
        .ctrl  (ctrl),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .imm   (imm)
    );

    regFile regFile_i (
        .clk       (clk),
        .run       (run),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .regWrite  (ctrl.regWrite),
        .writeData (writeBack),
        .readData1 (readData1),
        .readData2 (readData2),
        .a0        (a0),
        .a1        (a1),
        .a7        (a7)
    );

    alu alu_i (
        .srcA     (readData1),
        .srcB     (srcB),
        .aluOp    (ctrl.aluOp),
        .result   (aluResult),
        .zero     (zero),
        .lessThan (lessThan)
    );

    dataMemory dataMemory_i (
        .clk       (clk),
        .run       (run),
        .memWrite  (ctrl.memWrite),
        .resultSel (ctrl.resultSel),
        .addr      (aluResult),
        .writeData (readData2),
        .aluResult (aluResult),
        .pcPlus4   (pcPlus4),
        .result    (writeBack)
    );

endmodule

`default_nettype wire

/* design/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath and address width
`define XLEN 32

// Store depths in 32-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// Word index widths
`define IMEM_AW $clog2(`IMEM_WORDS)
`define DMEM_AW $clog2(`DMEM_WORDS)

`endif

/* design/rv_pkg.sv */
`include "rv_consts.svh"
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra
    } aluOpT;

    // Write-back source
    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPc4
    } resultSelT;

    typedef enum logic [1:0] {
        pcSelPlus4,
        pcSelBranch,
        pcSelJal,
        pcSelJalr
    } pcSelT;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immKindT;

    // Branch conditions are 00 eq, 01 ne, 10 lt and 11 ge
    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      aluSrcImm;
        aluOpT     aluOp;
        resultSelT resultSel;
        pcSelT     pcSel;
        logic [1:0] branchCond;
        immKindT   immKind;
    } ctrlT;

    // One word of the program load port
    typedef struct packed {
        logic [`IMEM_AW-1:0] addr;
        logic [`XLEN-1:0]    data;
    } loadWordT;

endpackage

`default_nettype wire

/* rvCore.f */
+incdir+design
design/rv_pkg.sv
design/fetchUnit.sv
design/decoder.sv
design/regFile.sv
design/alu.sv
design/dataMemory.sv
design/rvCore.sv
sim/rvCore_assertions.sv
sim/rvCore_tb.sv

/* sim/rvCore_assertions.sv */
`include "rv_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module rvCoreAssertions (
    input logic             clk,
    input logic             rst,
    input logic             run,
    input logic             loadReq,
    input logic             loadAck,
    input logic [`XLEN-1:0] pc
);

    // Ack only answers a request made in load mode
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(loadAck) |-> $past(loadReq && !run))
        else $error("loadAck rose without a load-mode request");

    // Ack drops on the edge after the request is withdrawn
    ackReleases: assert property (@(posedge clk) disable iff (rst)
        (loadAck && !loadReq) |=> !loadAck)
        else $error("loadAck still high one cycle after loadReq fell");

    pcAligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00)
        else $error("PC 0x%08h is not word aligned", pc);

endmodule

`default_nettype wire

/* sim/rvCore_tb.sv */
`include "rv_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module rvCore_tb import rv_pkg::*; ();

    logic             clk;
    logic             rst;
    logic             run;
    logic             loadReq;
    loadWordT         loadWord;
    logic             loadAck;
    logic [`XLEN-1:0] a0;
    logic [`XLEN-1:0] a1;
    logic [`XLEN-1:0] a7;

    // Test table read from the data file
    string            testName[$];
    int               wordCount[$];
    int               cycleBudget[$];
    int               stallCycles[$];
    int               firstWord[$];
    logic [`XLEN-1:0] progWords[$];
    logic [`XLEN-1:0] expA0[$];
    logic [`XLEN-1:0] expA1[$];
    logic [`XLEN-1:0] expA7[$];

    int cycleCount = 0;
    int cycleLimit = 0;
    int fileErrors = 0;
    int passed     = 0;
    int failed     = 0;

    rvCore dut_i (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .loadReq  (loadReq),
        .loadWord (loadWord),
        .loadAck  (loadAck),
        .a0       (a0),
        .a1       (a1),
        .a7       (a7)
    );

    bind fetchUnit rvCoreAssertions assertions_i (
        .clk     (clk),
        .rst     (rst),
        .run     (run),
        .loadReq (loadReq),
        .loadAck (loadAck),
        .pc      (pc)
    );

    always #4 clk = ~clk;

    // Watchdog limit is set once the tests are known
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: no finish within %0d cycles", cycleLimit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic readTests();
        int               fd;
        int               code;
        int               i;
        string            tok;
        string            line;
        string            name;
        int               words;
        int               budget;
        int               stall;
        logic [`XLEN-1:0] value;
        logic [`XLEN-1:0] v0;
        logic [`XLEN-1:0] v1;
        logic [`XLEN-1:0] v2;
        fd = $fopen("sim/rvCore_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test data file sim/rvCore_tests.txt");
            fileErrors++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.getc(0) == 8'h23) begin
                    code = $fgets(line, fd);
                end else if (tok == "test") begin
                    code = $fscanf(fd, "%s %d %d %d", name, words, budget, stall);
                    testName.push_back(name);
                    wordCount.push_back(words);
                    cycleBudget.push_back(budget);
                    stallCycles.push_back(stall);
                    firstWord.push_back(progWords.size());
                    for (i = 0; i < words; i++) begin
                        code = $fscanf(fd, "%h", value);
                        if (code != 1) begin
                            $display("Test %s has fewer program words than declared", name);
                            fileErrors++;
                        end
                        progWords.push_back(value);
                    end
                end else if (tok == "expect") begin
                    code = $fscanf(fd, "%h %h %h", v0, v1, v2);
                    expA0.push_back(v0);
                    expA1.push_back(v1);
                    expA7.push_back(v2);
                end else begin
                    $display("Unexpected token %s in the test data file", tok);
                    fileErrors++;
                end
            end
            $fclose(fd);
            if (expA0.size() != testName.size()) begin
                $display("Every test in the data file needs one expect line");
                fileErrors++;
            end
        end
    endtask

    // One four-phase transfer with run optionally raised while the request waits
    task automatic loadProgramWord(input int addr, input logic [`XLEN-1:0] data,
                                   input int stall, inout int bad);
        loadWord.addr = addr[`IMEM_AW-1:0];
        loadWord.data = data;
        loadReq = 1'b1;
        if (stall > 0) begin
            run = 1'b1;
            repeat (stall) begin
                @(negedge clk);
                assert (loadAck === 1'b0) else begin
                    $display("** Error at %0t: loadAck = %b, expected 0 while run is high",
                             $time, loadAck);
                    bad++;
                end
            end
            run = 1'b0;
        end
        do @(negedge clk); while (loadAck !== 1'b1);
        loadReq = 1'b0;
        do @(negedge clk); while (loadAck !== 1'b0);
    endtask

    task automatic checkRegister(input string regName, input logic [`XLEN-1:0] got,
                                 input logic [`XLEN-1:0] exp, inout int bad);
        assert (got === exp) else begin
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, regName, got, exp);
            bad++;
        end
    endtask

    initial begin
        int t;
        int w;
        int bad;
        clk      = 1'b0;
        rst      = 1'b1;
        run      = 1'b0;
        loadReq  = 1'b0;
        loadWord = '0;
        readTests();

        // Reset, load handshakes and run budgets plus slack
        cycleLimit = 8 + 200;
        for (t = 0; t < testName.size(); t++) begin
            cycleLimit += cycleBudget[t] + stallCycles[t] + 4 * wordCount[t] + 2;
        end

        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (t = 0; t < testName.size(); t++) begin
            bad = 0;
            for (w = 0; w < wordCount[t]; w++) begin
                loadProgramWord(w, progWords[firstWord[t] + w],
                                (w == 0) ? stallCycles[t] : 0, bad);
            end
            run = 1'b1;
            repeat (cycleBudget[t]) @(negedge clk);
            run = 1'b0;
            @(negedge clk);
            checkRegister("a0", a0, expA0[t], bad);
            checkRegister("a1", a1, expA1[t], bad);
            checkRegister("a7", a7, expA7[t], bad);
            if (bad == 0) begin
                passed++;
                $display("Test %s: ok", testName[t]);
            end else begin
                failed++;
                $display("Test %s: %0d mismatches", testName[t], bad);
            end
        end

        $display("Tests run %0d, passed %0d, failed %0d", testName.size(), passed, failed);
        if (failed == 0 && fileErrors == 0 && testName.size() > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/rvCore_tests.txt */
# Test line holds name, word count, cycle budget and stall cycles
# Program words in hex follow, then expect with a0 a1 a7 in hex

# R-type arithmetic, logic and shifts with a negative operand
test regreg 14 24 0
ff900293 00300313 40628533 4062d5b3 0062a3b3 0062be33 00639eb3
007ee8b3 0068c8b3 01c888b3 0062df33 01e5f5b3 01d50533 0000006f
expect fffffffe 1fffffff 0000000a

# Immediate forms and lui constants, x0 stays zero
test immlui 19 28 0
12345537 67850513 fffff5b7 0f05e593 fff5c593 7f35f593 00500013
abcde037 01100893 01b89293 4042d313 0042d393 00032e13 0013be93
00734333 01c888b3 01d888b3 006888b3 0000006f
expect 12345678 00000703 f0000012

# Stores then loads at several word addresses
test memory 19 28 0
deadc2b7 eef28293 12300313 04000393 0053a023 0063a223 3fc00e13
006e2023 fe53a823 0003a503 0043a583 000e2e83 ff03af03 01d585b3
00af4fb3 00b3a223 0043a883 01f888b3 0000006f
expect deadbeef 00000246 00000246

# Sum of 1 to 10 in a blt and bne loop, bge exit
test loop 14 80 0
00000513 00000593 00a00293 00100313 00650533 00158593 00130313
0062c663 fe0318e3 fff00513 0055d463 fff00593 05a00893 00000063
expect 00000037 0000000a 0000005a

# jal and jalr link into a7 and skip writes to a0
test jump 12 20 0
00100513 00c008ef 7ff00513 7fe00513 00088593 02400293 001288e7
fff00513 ffe00513 00250513 011585b3 0000006f
expect 00000003 00000024 0000001c

# First load request waits while run is high
test stall 5 12 6
0cafe537 12350513 f9c00593 4025d893 0000006f
expect 0cafe123 ffffff9c ffffffe7
